// ==== compile.f ====
hdl/rayPkg.sv
hdl/sceneRegs.sv
hdl/fixedDivider.sv
hdl/raySetup.sv
hdl/ddaWalker.sv
hdl/rayCaster.sv
tb/clkRst.sv
tb/rayCasterTb.sv

// ==== hdl/ddaWalker.sv ====
`timescale 1ns/1ps

module ddaWalker (
  input  logic           pixel_clk_in,
  input  logic           rst_in,
  input  logic           setupValid,
  input  rayPkg::col_t   col,
  input  rayPkg::cell_t  stepX,
  input  rayPkg::cell_t  stepY,
  input  rayPkg::cell_t  mapX,
  input  rayPkg::cell_t  mapY,
  input  rayPkg::fixed_t deltaDistX,
  input  rayPkg::fixed_t deltaDistY,
  input  rayPkg::fixed_t sideDistX,
  input  rayPkg::fixed_t sideDistY,
  input  logic           wallHit,
  input  logic           creditReturn,
  output logic           walkIdle,
  output rayPkg::cell_t  probeX,
  output rayPkg::cell_t  probeY,
  output logic           colValid,
  output rayPkg::col_t   colIndex,
  output rayPkg::cell_t  hitX,
  output rayPkg::cell_t  hitY,
  output logic           hitSide,
  output rayPkg::fixed_t wallDist,
  output logic           frameDone
);
  import rayPkg::*;

  typedef enum logic [2:0] {IDLE, WALK, SEL, DIST, OUT} walkState_t;
  walkState_t state;

  col_t curCol;
  cell_t curX;
  cell_t curY;
  cell_t stepXq;
  cell_t stepYq;
  fixed_t sideX;
  fixed_t sideY;
  fixed_t deltaX;
  fixed_t deltaY;
  fixed_t selSide;
  fixed_t selDelta;
  logic lastSideY;  // 1 when the last step crossed a y boundary
  logic found;      // 0 means the step limit ran out
  logic [5:0] stepCount;
  logic [2:0] credits;
  logic takeX;
  logic lastStep;
  logic [15:0] sumX;
  logic [15:0] sumY;
  fixed_t nextSideX;
  fixed_t nextSideY;

  assign walkIdle = state == IDLE;
  assign colValid = state == OUT && credits != '0; // hold column while out of credit
  assign frameDone = colValid && colIndex == col_t'(SCREEN_WIDTH - 1);

  always_comb begin
    takeX = sideX < sideY;          // nearer boundary first
    probeX = takeX ? curX + stepXq : curX;
    probeY = takeX ? curY : curY + stepYq;
    sumX = sideX + deltaX;          // both nonnegative, bit 15 means overflow
    sumY = sideY + deltaY;
    nextSideX = sumX[15] ? FIXED_MAX : fixed_t'(sumX);
    nextSideY = sumY[15] ? FIXED_MAX : fixed_t'(sumY);
    lastStep = stepCount == 6'(MAX_STEPS - 1);
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      state <= IDLE;
      stepCount <= '0;
      credits <= 3'(CREDIT_MAX);
    end else begin
      credits <= credits + 3'(creditReturn) - 3'(colValid); // return and spend may coincide
      case (state)
        IDLE: begin
          if (setupValid) begin
            stepCount <= '0;
            state <= WALK;
          end
        end
        WALK: begin
          stepCount <= stepCount + 1'b1;
          if (wallHit || lastStep) state <= SEL;
        end
        SEL: state <= DIST;
        DIST: state <= OUT;
        OUT: if (credits != '0) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    case (state)
      IDLE: begin
        if (setupValid) begin  // take the column from setup
          curCol <= col;
          curX <= mapX;
          curY <= mapY;
          stepXq <= stepX;
          stepYq <= stepY;
          sideX <= sideDistX;
          sideY <= sideDistY;
          deltaX <= deltaDistX;
          deltaY <= deltaDistY;
        end
      end
      WALK: begin
        curX <= probeX;
        curY <= probeY;
        if (takeX) sideX <= nextSideX;
        else sideY <= nextSideY;
        lastSideY <= !takeX;
        found <= wallHit;
      end
      SEL: begin
        selSide <= lastSideY ? sideY : sideX;
        selDelta <= lastSideY ? deltaY : deltaX;
      end
      DIST: begin
        // perpendicular distance, one delta back from the crossed boundary
        wallDist <= found ? selSide - selDelta : FIXED_MAX;
        colIndex <= curCol;
        hitX <= curX;
        hitY <= curY;
        hitSide <= lastSideY;
      end
      default: ;
    endcase
  end

  // downstream never frees more than it was sent
  creditBound: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    credits <= 3'(CREDIT_MAX));

endmodule

// ==== hdl/fixedDivider.sv ====
`timescale 1ns/1ps

module fixedDivider (
  input  logic           pixel_clk_in,
  input  logic           rst_in,
  input  logic           start,
  input  rayPkg::fixed_t dividend,
  input  rayPkg::fixed_t divisor,
  output logic           busy,
  output logic           done,
  output rayPkg::fixed_t quotient,
  output logic           dbz
);
  import rayPkg::*;

  typedef enum logic [1:0] {IDLE, ITER, FINISH} divState_t;
  divState_t state;

  logic [15:0] divMag;    // |divisor| latched at start
  logic [15:0] lowBits;   // numerator bits not yet shifted in
  logic [15:0] rem;
  logic [15:0] quoMag;
  logic [3:0]  iterCount;
  logic        negResult;
  logic        overflow;  // quotient would not fit in 16 bits
  logic        zeroDiv;

  logic [15:0] dividendMag;
  logic [15:0] divisorMag;
  logic [23:0] numerator; // |dividend| << 8 keeps the result in Q8.8
  logic [16:0] trial;
  logic        trialFits;

  always_comb begin
    dividendMag = dividend[15] ? 16'(-dividend) : 16'(dividend);
    divisorMag = divisor[15] ? 16'(-divisor) : 16'(divisor);
    numerator = {dividendMag, 8'h00};
    trial = {rem, lowBits[15]};          // shift next numerator bit in
    trialFits = trial >= {1'b0, divMag};
  end

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      state <= IDLE;
      busy <= 1'b0;
      done <= 1'b0;
      dbz <= 1'b0;
    end else begin
      done <= 1'b0; // single cycle pulse
      case (state)
        IDLE: begin
          if (start) begin
            busy <= 1'b1;
            state <= ITER;
          end
        end
        ITER: if (iterCount == 4'd15) state <= FINISH;
        FINISH: begin
          busy <= 1'b0;
          done <= 1'b1;
          dbz <= zeroDiv;
          state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge pixel_clk_in) begin
    if (state == IDLE && start) begin
      divMag <= divisorMag;
      rem <= {8'h00, numerator[23:16]};
      lowBits <= numerator[15:0];
      overflow <= numerator[23:16] >= divisorMag; // upper bits alone already exceed
      zeroDiv <= divisor == '0;
      negResult <= dividend[15] ^ divisor[15];
      quoMag <= '0;
      iterCount <= '0;
    end else if (state == ITER) begin
      rem <= trialFits ? 16'(trial - {1'b0, divMag}) : trial[15:0];
      quoMag <= {quoMag[14:0], trialFits};
      lowBits <= lowBits << 1;
      iterCount <= iterCount + 1'b1;
    end else if (state == FINISH) begin
      if (zeroDiv || overflow || quoMag[15]) quotient <= FIXED_MAX; // saturate
      else quotient <= negResult ? -fixed_t'(quoMag) : fixed_t'(quoMag);
    end
  end

  // caller must wait for done before the next operand pair
  noStartWhileBusy: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    start |-> !busy);

endmodule

// ==== hdl/rayCaster.sv ====
`timescale 1ns/1ps

module rayCaster (
  input  logic             pixel_clk_in,
  input  logic             rst_in,
  input  logic             regWe,
  input  rayPkg::regAddr_t regAddr,
  input  logic [15:0]      regWdata,
  input  logic             frameStart,
  input  logic             creditReturn,
  output logic             colValid,
  output rayPkg::col_t     colIndex,
  output rayPkg::cell_t    hitX,
  output rayPkg::cell_t    hitY,
  output logic             hitSide,
  output rayPkg::fixed_t   wallDist,
  output logic             frameDone
);
  import rayPkg::*;

  // camera registers
  fixed_t posX;
  fixed_t posY;
  fixed_t dirX;
  fixed_t dirY;
  fixed_t planeX;
  fixed_t planeY;

  // setup to walker, one column at a time
  logic setupValid;
  logic walkIdle;
  col_t col;
  cell_t stepX;
  cell_t stepY;
  cell_t mapX;
  cell_t mapY;
  fixed_t deltaDistX;
  fixed_t deltaDistY;
  fixed_t sideDistX;
  fixed_t sideDistY;

  // map probe loop
  cell_t probeX;
  cell_t probeY;
  logic wallHit;

  sceneRegs sceneRegs_inst (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in),
    .regWe(regWe), .regAddr(regAddr), .regWdata(regWdata),
    .probeX(probeX), .probeY(probeY),
    .posX(posX), .posY(posY), .dirX(dirX), .dirY(dirY),
    .planeX(planeX), .planeY(planeY), .wallHit(wallHit)
  );

  raySetup raySetup_inst (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in), .frameStart(frameStart),
    .posX(posX), .posY(posY), .dirX(dirX), .dirY(dirY),
    .planeX(planeX), .planeY(planeY), .walkIdle(walkIdle),
    .setupValid(setupValid), .col(col), .stepX(stepX), .stepY(stepY),
    .mapX(mapX), .mapY(mapY), .deltaDistX(deltaDistX), .deltaDistY(deltaDistY),
    .sideDistX(sideDistX), .sideDistY(sideDistY)
  );

  ddaWalker ddaWalker_inst (
    .pixel_clk_in(pixel_clk_in), .rst_in(rst_in), .setupValid(setupValid),
    .col(col), .stepX(stepX), .stepY(stepY), .mapX(mapX), .mapY(mapY),
    .deltaDistX(deltaDistX), .deltaDistY(deltaDistY),
    .sideDistX(sideDistX), .sideDistY(sideDistY),
    .wallHit(wallHit), .creditReturn(creditReturn), .walkIdle(walkIdle),
    .probeX(probeX), .probeY(probeY), .colValid(colValid), .colIndex(colIndex),
    .hitX(hitX), .hitY(hitY), .hitSide(hitSide), .wallDist(wallDist),
    .frameDone(frameDone)
  );

endmodule

// ==== hdl/rayPkg.sv ====
package rayPkg;

  typedef logic signed [15:0] fixed_t; // Q8.8, 8 integer bits incl sign
  typedef logic [3:0] cell_t;          // one map cell coordinate
  typedef logic [8:0] col_t;           // screen column 0..319
  typedef logic [4:0] regAddr_t;

  // screen and map geometry
  localparam int SCREEN_WIDTH = 320;
  localparam logic [15:0] INV_HALF_WIDTH = 16'd410; // 2/320 in Q0.16
  localparam int MAP_SIZE = 16;

  // downstream may hold this many columns
  localparam int CREDIT_MAX = 4;

  localparam fixed_t FIXED_ONE = 16'sh0100;
  localparam fixed_t FIXED_MAX = 16'sh7fff; // also the "no wall" distance

  // grid walk gives up after this many cells
  localparam int MAX_STEPS = 32;

  // register map
  localparam regAddr_t ADDR_POS_X = 5'd0;
  localparam regAddr_t ADDR_POS_Y = 5'd1;
  localparam regAddr_t ADDR_DIR_X = 5'd2;
  localparam regAddr_t ADDR_DIR_Y = 5'd3;
  localparam regAddr_t ADDR_PLANE_X = 5'd4;
  localparam regAddr_t ADDR_PLANE_Y = 5'd5;
  localparam regAddr_t ADDR_MAP_BASE = 5'd16; // rows 0..15 at 16..31

  // scene after reset
  localparam fixed_t RESET_POS = 16'sh0280;   // 2.5
  localparam fixed_t RESET_DIR_X = FIXED_ONE; // looking along +x
  localparam fixed_t RESET_DIR_Y = 16'sh0000;
  localparam fixed_t RESET_PLANE_X = 16'sh0000;
  localparam fixed_t RESET_PLANE_Y = 16'sh00a9; // 0.66, about 66 deg fov
  localparam logic [15:0] ROW_SOLID = 16'hffff; // top and bottom rows
  localparam logic [15:0] ROW_BORDER = 16'h8001; // only cells 0 and 15

endpackage

// ==== hdl/raySetup.sv ====
`timescale 1ns/1ps

module raySetup (
  input  logic           pixel_clk_in,
  input  logic           rst_in,
  input  logic           frameStart,
  input  rayPkg::fixed_t posX,
  input  rayPkg::fixed_t posY,
  input  rayPkg::fixed_t dirX,
  input  rayPkg::fixed_t dirY,
  input  rayPkg::fixed_t planeX,
  input  rayPkg::fixed_t planeY,
  input  logic           walkIdle,
  output logic           setupValid,
  output rayPkg::col_t   col,
  output rayPkg::cell_t  stepX,
  output rayPkg::cell_t  stepY,
  output rayPkg::cell_t  mapX,
  output rayPkg::cell_t  mapY,
  output rayPkg::fixed_t deltaDistX,
  output rayPkg::fixed_t deltaDistY,
  output rayPkg::fixed_t sideDistX,
  output rayPkg::fixed_t sideDistY
);
  import rayPkg::*;

  typedef enum logic [2:0] {IDLE, CAM, DIR, DIV, VALID} setupState_t;
  setupState_t state;

  fixed_t camX;                      // -1 at left edge, 0 at center
  logic [24:0] camProd;
  logic signed [31:0] planeProdX;
  logic signed [31:0] planeProdY;
  fixed_t rayDirX;                   // live from camX and the camera regs
  fixed_t rayDirY;
  fixed_t rayDirXq;                  // frozen for this column
  fixed_t rayDirYq;
  logic [7:0] posFracX;
  logic [7:0] posFracY;
  logic divStart;
  logic divDoneX;
  logic divDoneY;
  fixed_t recipX;
  fixed_t recipY;
  fixed_t absRecipX;
  fixed_t absRecipY;
  logic [8:0] fracX;                 // distance to the first boundary, 0..1
  logic [8:0] fracY;
  logic [24:0] sideProdX;
  logic [24:0] sideProdY;
  logic handoff;

  assign handoff = setupValid && walkIdle;
  assign divStart = state == DIR;    // both dividers run in lockstep

  always_comb begin
    camProd = col * INV_HALF_WIDTH;  // Q9.16, 2*col/width
    planeProdX = planeX * camX;
    planeProdY = planeY * camX;
    rayDirX = dirX + fixed_t'(planeProdX[23:8]);
    rayDirY = dirY + fixed_t'(planeProdY[23:8]);
    absRecipX = recipX[15] ? -recipX : recipX;
    absRecipY = recipY[15] ? -recipY : recipY;
    // looking back means the near boundary is the cell floor
    fracX = rayDirXq[15] ? {1'b0, posFracX} : 9'(FIXED_ONE) - {1'b0, posFracX};
    fracY = rayDirYq[15] ? {1'b0, posFracY} : 9'(FIXED_ONE) - {1'b0, posFracY};
    sideProdX = fracX * absRecipX;   // at most 1.0 times FIXED_MAX, no overflow
    sideProdY = fracY * absRecipY;
  end

  fixedDivider recipDivX (
    .pixel_clk_in(pixel_clk_in),
    .rst_in      (rst_in),
    .start       (divStart),
    .dividend    (FIXED_ONE),
    .divisor     (rayDirX),
    .busy        (),
    .done        (divDoneX),
    .quotient    (recipX),
    .dbz         ()             // quotient already saturated
  );

  fixedDivider recipDivY (
    .pixel_clk_in(pixel_clk_in),
    .rst_in      (rst_in),
    .start       (divStart),
    .dividend    (FIXED_ONE),
    .divisor     (rayDirY),
    .busy        (),
    .done        (divDoneY),
    .quotient    (recipY),
    .dbz         ()
  );

  // column sequencing
  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      state <= IDLE;
      setupValid <= 1'b0;
      col <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (frameStart && walkIdle) begin // walker idle too, frame fully drained
            col <= '0;
            state <= CAM;
          end
        end
        CAM: state <= DIR;
        DIR: state <= DIV;
        DIV: begin
          if (divDoneX && divDoneY) begin
            setupValid <= 1'b1;
            state <= VALID;
          end
        end
        VALID: begin
          if (handoff) begin
            setupValid <= 1'b0;
            if (col == col_t'(SCREEN_WIDTH - 1)) begin
              state <= IDLE;
            end else begin
              col <= col + 1'b1;
              state <= CAM; // next column overlaps this walk
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // per column datapath
  always_ff @(posedge pixel_clk_in) begin
    if (state == CAM) begin
      camX <= fixed_t'(camProd >> 8) - FIXED_ONE;
    end
    if (state == DIR) begin
      rayDirXq <= rayDirX;
      rayDirYq <= rayDirY;
      posFracX <= posX[7:0];
      posFracY <= posY[7:0];
      mapX <= posX[11:8];       // integer part, map is only 16 wide
      mapY <= posY[11:8];
      stepX <= rayDirX[15] ? 4'hf : 4'h1; // -1 wraps in cell_t
      stepY <= rayDirY[15] ? 4'hf : 4'h1;
    end
    if (state == DIV && divDoneX && divDoneY) begin
      deltaDistX <= absRecipX;
      deltaDistY <= absRecipY;
      sideDistX <= fixed_t'(sideProdX >> 8);
      sideDistY <= fixed_t'(sideProdY >> 8);
    end
  end

  // walker may lag behind, setup must not drift meanwhile
  setupHeld: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    setupValid && !walkIdle |=> setupValid && $stable(col) && $stable(sideDistX)
      && $stable(sideDistY));

endmodule

// ==== hdl/sceneRegs.sv ====
`timescale 1ns/1ps

module sceneRegs (
  input  logic             pixel_clk_in,
  input  logic             rst_in,
  input  logic             regWe,
  input  rayPkg::regAddr_t regAddr,
  input  logic [15:0]      regWdata,
  input  rayPkg::cell_t    probeX,
  input  rayPkg::cell_t    probeY,
  output rayPkg::fixed_t   posX,
  output rayPkg::fixed_t   posY,
  output rayPkg::fixed_t   dirX,
  output rayPkg::fixed_t   dirY,
  output rayPkg::fixed_t   planeX,
  output rayPkg::fixed_t   planeY,
  output logic             wallHit
);
  import rayPkg::*;

  logic [MAP_SIZE-1:0] mapRows [MAP_SIZE]; // row index is y, bit index is x

  always_ff @(posedge pixel_clk_in) begin
    if (rst_in) begin
      posX <= RESET_POS;
      posY <= RESET_POS;
      dirX <= RESET_DIR_X;
      dirY <= RESET_DIR_Y;
      planeX <= RESET_PLANE_X;
      planeY <= RESET_PLANE_Y;
      for (int r = 0; r < MAP_SIZE; r++) begin
        // closed room, walls on the border only
        mapRows[r] <= (r == 0 || r == MAP_SIZE - 1) ? ROW_SOLID : ROW_BORDER;
      end
    end else if (regWe) begin
      case (regAddr)
        ADDR_POS_X:   posX <= regWdata;
        ADDR_POS_Y:   posY <= regWdata;
        ADDR_DIR_X:   dirX <= regWdata;
        ADDR_DIR_Y:   dirY <= regWdata;
        ADDR_PLANE_X: planeX <= regWdata;
        ADDR_PLANE_Y: planeY <= regWdata;
        default: begin
          if (regAddr >= ADDR_MAP_BASE) begin
            mapRows[regAddr[3:0]] <= regWdata; // low nibble picks the row
          end
        end
      endcase
    end
  end

  // probe answered in the same cycle, walker steps once per clock
  assign wallHit = mapRows[probeY][probeX];

  // 6..15 is a hole in the map, software should never touch it
  holeNotWritten: assert property (@(posedge pixel_clk_in) disable iff (rst_in)
    regWe |-> !(regAddr inside {[5'd6:5'd15]}));

endmodule

// ==== tb/clkRst.sv ====
`timescale 1ns/1ps

module clkRst (
  output logic clk,
  output logic rst
);

  localparam int HALF_PERIOD = 2; // ns, 4 ns pixel clock
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0; // released on a falling edge, same as the other stimulus
  end

endmodule

// ==== tb/rayCasterTb.sv ====
`timescale 1ns/1ps

module rayCasterTb;
  import rayPkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int NUM_ROWS = 6;
  localparam int WATCH_CYCLES = NUM_ROWS * SCREEN_WIDTH * 60; // budget for every frame

  typedef struct {
    string name;
    fixed_t posX, posY, dirX, dirY, planeX, planeY;
    logic [15:0] row2;       // map row 2, the only row edited
    col_t col;               // column to observe
    cell_t expX, expY;
    logic expSide;           // 1 for a y face
    fixed_t expDist;
  } testRow_t;

  logic clk, rst;
  logic regWe, frameStart, creditReturn;
  regAddr_t regAddr;
  logic [15:0] regWdata;
  logic colValid, hitSide, frameDone;
  col_t colIndex;
  cell_t hitX, hitY;
  fixed_t wallDist;

  testRow_t testTable [NUM_ROWS];
  integer seed = 32'he6ab_3a74;
  integer randVal;
  int cycleCount = 0, lastDue = 0, outstanding = 0, delay, due;
  int returnQ [$];           // cycle numbers at which a credit goes back
  int expectedCol = 0, framesSeen = 0, activeRow = 0;
  logic frameActive = 1'b0, giveBack;
  cell_t obsX, obsY;
  logic obsSide;
  fixed_t obsDist;

  clkRst clkRst_inst (.clk(clk), .rst(rst));

  rayCaster rayCaster_inst (
    .pixel_clk_in(clk), .rst_in(rst), .regWe(regWe), .regAddr(regAddr),
    .regWdata(regWdata), .frameStart(frameStart), .creditReturn(creditReturn),
    .colValid(colValid), .colIndex(colIndex), .hitX(hitX), .hitY(hitY),
    .hitSide(hitSide), .wallDist(wallDist), .frameDone(frameDone)
  );

  task automatic abortRun();
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic checkCell(input string what, input cell_t expected, input cell_t actual);
    if (actual !== expected) begin
      $display("ERR %s expected %0d actual %0d", what, expected, actual);
      abortRun();
    end
  endtask

  task automatic checkCol(input string what, input col_t expected, input col_t actual);
    if (actual !== expected) begin
      $display("ERR %s expected %0d actual %0d", what, expected, actual);
      abortRun();
    end
  endtask

  task automatic checkFixed(input string what, input fixed_t expected, input fixed_t actual);
    int diff;
    diff = int'(actual) - int'(expected);
    if ($isunknown(actual) || diff > 1 || diff < -1) begin // one lsb of Q8.8 allowed
      $display("ERR %s expected %0d (0x%h) actual %0d (0x%h)", what, expected, expected,
               actual, actual);
      abortRun();
    end
  endtask

  task automatic checkBit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERR %s expected %b actual %b", what, expected, actual);
      abortRun();
    end
  endtask

  task automatic writeReg(input regAddr_t addr, input logic [15:0] data);
    @(negedge clk);
    regWe = 1'b1;
    regAddr = addr;
    regWdata = data;
    @(negedge clk);
    regWe = 1'b0; // lands on the edge in between
  endtask

  // downstream renderer, counts columns and hands credits back late
  always @(negedge clk) begin
    if (!rst) begin
      cycleCount++;
      giveBack = returnQ.size() > 0 && returnQ[0] <= cycleCount;
      if (giveBack) void'(returnQ.pop_front());
      creditReturn = giveBack;
      if (colValid) outstanding++;
      if (giveBack) outstanding--;
      if (outstanding > CREDIT_MAX || outstanding < 0) begin
        $display("credit violation: %0d columns outstanding", outstanding);
        abortRun();
      end
      if (colValid) begin
        if (!frameActive) begin
          $display("column %0d came out with no frame running", colIndex);
          abortRun();
        end
        checkCol("columnOrder", col_t'(expectedCol), colIndex);
        checkBit("frameDoneWithLast", expectedCol == SCREEN_WIDTH - 1, frameDone);
        if (colIndex == testTable[activeRow].col) begin
          obsX = hitX;
          obsY = hitY;
          obsSide = hitSide;
          obsDist = wallDist;
        end
        randVal = $random(seed);
        delay = (randVal[4:0] == 5'd0) ? 120 : int'(randVal[7:5]); // rare long stall
        due = cycleCount + 1 + delay;
        if (due <= lastDue) due = lastDue + 1; // one return per cycle, in order
        returnQ.push_back(due);
        lastDue = due;
        if (expectedCol == SCREEN_WIDTH - 1) begin
          expectedCol = 0;
          frameActive = 1'b0;
          framesSeen++;
        end else begin
          expectedCol++;
        end
      end else begin
        checkBit("frameDoneAlone", 1'b0, frameDone);
      end
    end
  end

  initial begin
    #(WATCH_CYCLES * CLK_PERIOD);
    $display("timeout: %0d frames done after %0d cycles", framesSeen, WATCH_CYCLES);
    abortRun();
  end

  initial begin
    regWe = 1'b0;
    regAddr = '0;
    regWdata = '0;
    frameStart = 1'b0;
    creditReturn = 1'b0;
    // border room, eye at (2.5, 2.5) unless moved; distances in Q8.8
    testTable[0] = '{"lookPlusX", 16'sh0280, 16'sh0280, 16'sh0100, 16'sh0000, 16'sh0000,
                     16'sh00a9, 16'h8001, 9'd160, 4'd15, 4'd2, 1'b0, 16'sh0c80};
    testTable[1] = '{"lookMinusX", 16'sh0280, 16'sh0280, 16'shff00, 16'sh0000, 16'sh0000,
                     16'shff57, 16'h8001, 9'd160, 4'd0, 4'd2, 1'b0, 16'sh0180};
    testTable[2] = '{"lookPlusY", 16'sh0280, 16'sh0280, 16'sh0000, 16'sh0100, 16'shff57,
                     16'sh0000, 16'h8001, 9'd160, 4'd2, 4'd15, 1'b1, 16'sh0c80};
    testTable[3] = '{"lookMinusY", 16'sh0280, 16'sh0280, 16'sh0000, 16'shff00, 16'sh00a9,
                     16'sh0000, 16'h8001, 9'd160, 4'd2, 4'd0, 1'b1, 16'sh0180};
    testTable[4] = '{"offsetPos", 16'sh0540, 16'sh07c0, 16'sh0100, 16'sh0000, 16'sh0000,
                     16'sh00a9, 16'h8001, 9'd160, 4'd15, 4'd7, 1'b0, 16'sh09c0};
    testTable[5] = '{"nearWall", 16'sh0280, 16'sh0280, 16'sh0100, 16'sh0000, 16'sh0000,
                     16'sh00a9, 16'h8041, 9'd160, 4'd6, 4'd2, 1'b0, 16'sh0380};
    while (rst) @(negedge clk);
    repeat (100) begin // idle after reset, nothing may come out
      @(negedge clk);
      if (colValid || frameDone) begin
        $display("output active after reset without a frame start");
        abortRun();
      end
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      writeReg(ADDR_POS_X, testTable[i].posX);
      writeReg(ADDR_POS_Y, testTable[i].posY);
      writeReg(ADDR_DIR_X, testTable[i].dirX);
      writeReg(ADDR_DIR_Y, testTable[i].dirY);
      writeReg(ADDR_PLANE_X, testTable[i].planeX);
      writeReg(ADDR_PLANE_Y, testTable[i].planeY);
      writeReg(ADDR_MAP_BASE + 5'd2, testTable[i].row2);
      activeRow = i;
      frameActive = 1'b1;
      @(negedge clk);
      frameStart = 1'b1;
      @(negedge clk);
      frameStart = 1'b0;
      wait (framesSeen == i + 1); // watchdog covers a stuck frame
      checkCell({testTable[i].name, " hitX"}, testTable[i].expX, obsX);
      checkCell({testTable[i].name, " hitY"}, testTable[i].expY, obsY);
      checkBit({testTable[i].name, " hitSide"}, testTable[i].expSide, obsSide);
      checkFixed({testTable[i].name, " wallDist"}, testTable[i].expDist, obsDist);
      repeat (4) @(negedge clk);
    end
    wait (outstanding == 0); // every credit back home
    $display("*** PASSED ***");
    $finish;
  end

endmodule
